// ==== filelist.f ====
+incdir+verilog
verilog/copy_pkg.sv
verilog/copy_regs.sv
verilog/copy_engine.sv
verilog/burst_merge.sv
verilog/burst_to_axi.sv
verilog/copy_accel_top.sv
tests/tb_clock.sv
tests/axi_mem_model.sv
tests/tb_copy_accel.sv

// ==== Bender.yml ====
package:
  name: copy_accel

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/copy_pkg.sv
      - verilog/copy_regs.sv
      - verilog/copy_engine.sv
      - verilog/burst_merge.sv
      - verilog/burst_to_axi.sv
      - verilog/copy_accel_top.sv
      - target: test
        files:
          - tests/tb_clock.sv
          - tests/axi_mem_model.sv
          - tests/tb_copy_accel.sv

// ==== tests/tb_copy_accel.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "copy_macros.svh"

module tb_copy_accel;
  import copy_pkg::*;

  localparam int MAX_CYCLES = 20000;  // About four times the stalled run
  localparam int MEM_WORDS  = 1024;
  localparam logic [`COPY_REG_ADDR_W-1:0] STATUS_ADDR = 6'h20;

  logic                         clk;
  logic                         rst;
  logic                         valid;
  logic [`COPY_REG_ADDR_W-1:0]  addr;
  data_t                        wdata;
  strb_t                        wstrb;
  logic                         ready;
  data_t                        rdata;
  logic        axi_awvalid;
  logic        axi_awready;
  addr_t       axi_awaddr;
  len_t        axi_awlen;
  logic [2:0]  axi_awsize;
  logic [1:0]  axi_awburst;
  logic        axi_wvalid;
  logic        axi_wready;
  data_t       axi_wdata;
  strb_t       axi_wstrb;
  logic        axi_wlast;
  logic        axi_bready;
  logic        axi_arvalid;
  logic        axi_arready;
  addr_t       axi_araddr;
  len_t        axi_arlen;
  logic [2:0]  axi_arsize;
  logic [1:0]  axi_arburst;
  logic        axi_rvalid;
  logic        axi_rready;
  data_t       axi_rdata;
  logic        axi_rlast;

  data_t image [MEM_WORDS];       // Memory before the current test
  data_t expect_img [MEM_WORDS];
  len_t  dst_len [MEM_WORDS];     // Burst length expected at each destination word
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;

  tb_clock u_clock (.clk(clk), .rst(rst));

  copy_accel_top DUT (.*);

  axi_mem_model u_mem (
    .clk(clk), .rst(rst),
    .awvalid(axi_awvalid), .awready(axi_awready), .awaddr(axi_awaddr),
    .wvalid(axi_wvalid), .wready(axi_wready), .wdata(axi_wdata),
    .wstrb(axi_wstrb), .wlast(axi_wlast),
    .bvalid(), .bready(axi_bready),
    .arvalid(axi_arvalid), .arready(axi_arready), .araddr(axi_araddr),
    .arlen(axi_arlen),
    .rvalid(axi_rvalid), .rready(axi_rready), .rdata(axi_rdata), .rlast(axi_rlast)
  );

  // Copied range takes the source words, all else keeps its value
  function automatic data_t expected_word(int w, addr_t src, addr_t dst, len_t len);
    int first;
    first = int'(dst >> 2);
    if (w >= first && w <= first + int'(len)) begin
      return image[int'(src >> 2) + w - first];
    end
    return image[w];
  endfunction

  task automatic check_equal(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic bus_access(input logic [5:0] a, input data_t d, input strb_t s,
                            output data_t q);
    @(posedge clk);
    valid <= 1'b1;
    addr  <= a;
    wdata <= d;
    wstrb <= s;
    @(negedge clk);
    while (!ready) @(negedge clk);
    q = rdata;
    @(posedge clk);
    valid <= 1'b0;
    wstrb <= '0;
  endtask

  task automatic reg_write(input logic [5:0] a, input data_t d);
    data_t unused;
    bus_access(a, d, '1, unused);
  endtask

  task automatic reg_read(input logic [5:0] a, output data_t q);
    bus_access(a, '0, '0, q);
  endtask

  function automatic logic [5:0] reg_addr(int unit, int idx);
    return 6'(unit * 16 + idx * 4);
  endfunction

  task automatic configure(input int unit, input addr_t src, input addr_t dst, input len_t len);
    reg_write(reg_addr(unit, 0), src);
    reg_write(reg_addr(unit, 1), dst);
    reg_write(reg_addr(unit, 2), data_t'(len));
  endtask

  task automatic start_unit(input int unit);
    reg_write(reg_addr(unit, 3), 32'h1);
  endtask

  task automatic wait_idle();
    data_t st;
    reg_read(STATUS_ADDR, st);
    while (st[`COPY_N_UNITS-1:0] != '0) reg_read(STATUS_ADDR, st);
  endtask

  task automatic expect_copy(input addr_t src, input addr_t dst, input len_t len);
    dst_len[int'(dst >> 2)] = len;
    for (int i = 0; i <= int'(len); i++) begin
      expect_img[int'(dst >> 2) + i] = expected_word(int'(dst >> 2) + i, src, dst, len);
    end
  endtask

  task automatic check_memory(input string name);
    for (int w = 0; w < MEM_WORDS; w++) begin
      check_equal(u_mem.mem[w], expect_img[w], $sformatf("%s word %0d", name, w));
      image[w] = expect_img[w];
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d mismatches", num, name, errors - errs_before);
    end
  endtask

  // Burst attributes that the memory model does not decode
  always @(negedge clk) begin
    if (axi_awvalid && axi_awready) begin
      check_equal(data_t'(axi_awlen), data_t'(dst_len[int'(axi_awaddr >> 2)]), "AW length");
      check_equal(data_t'(axi_awsize), 32'd2, "AW size");  // 4-byte beats
      check_equal(data_t'(axi_awburst), 32'd1, "AW burst");  // INCR
      check_equal(data_t'(axi_bready), 32'd1, "B ready");
    end
    if (axi_arvalid && axi_arready) begin
      check_equal(data_t'(axi_arsize), 32'd2, "AR size");
      check_equal(data_t'(axi_arburst), 32'd1, "AR burst");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: no result after %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    data_t q;
    int    e;
    valid = 1'b0;
    addr  = '0;
    wdata = '0;
    wstrb = '0;
    @(negedge rst);
    for (int w = 0; w < MEM_WORDS; w++) begin
      image[w]      = u_mem.mem[w];
      expect_img[w] = u_mem.mem[w];
    end

    e = errors;
    reg_read(STATUS_ADDR, q);
    check_equal(q, '0, "STATUS after reset");
    configure(0, 32'h0000_0140, 32'h0000_0480, 8'd7);
    configure(1, 32'h0000_0a00, 32'h0000_0c40, 8'd15);
    reg_read(reg_addr(0, 0), q);
    check_equal(q, 32'h0000_0140, "unit 0 SRC");
    reg_read(reg_addr(0, 1), q);
    check_equal(q, 32'h0000_0480, "unit 0 DST");
    reg_read(reg_addr(0, 2), q);
    check_equal(q, 32'd7, "unit 0 LEN");
    reg_read(reg_addr(1, 0), q);
    check_equal(q, 32'h0000_0a00, "unit 1 SRC");
    reg_read(reg_addr(1, 1), q);
    check_equal(q, 32'h0000_0c40, "unit 1 DST");
    reg_read(reg_addr(1, 2), q);
    check_equal(q, 32'd15, "unit 1 LEN");
    report_test(1, "register access", e);

    e = errors;
    configure(0, 32'h0000_0100, 32'h0000_0400, 8'd7);
    expect_copy(32'h0000_0100, 32'h0000_0400, 8'd7);
    start_unit(0);
    wait_idle();
    check_memory("single copy");
    report_test(2, "single unit copy", e);

    e = errors;
    configure(1, 32'h0000_0200, 32'h0000_0600, 8'd15);
    expect_copy(32'h0000_0200, 32'h0000_0600, 8'd15);
    start_unit(1);
    wait_idle();
    check_memory("max burst");
    report_test(3, "maximum burst", e);

    e = errors;
    configure(0, 32'h0000_0800, 32'h0000_0a00, 8'd10);
    configure(1, 32'h0000_0880, 32'h0000_0b00, 8'd15);
    expect_copy(32'h0000_0800, 32'h0000_0a00, 8'd10);
    expect_copy(32'h0000_0880, 32'h0000_0b00, 8'd15);
    start_unit(0);
    start_unit(1);
    wait_idle();
    check_memory("concurrent");
    report_test(4, "concurrent units", e);

    e = errors;
    configure(0, 32'h0000_0c00, 32'h0000_0d00, 8'd15);
    expect_copy(32'h0000_0c00, 32'h0000_0d00, 8'd15);
    start_unit(0);
    configure(0, 32'h0000_0c80, 32'h0000_0e00, 8'd5);  // Next copy, stored only
    reg_read(STATUS_ADDR, q);
    check_equal(data_t'(q[0]), 32'd1, "unit 0 busy during copy");
    start_unit(0);  // Ignored while busy
    wait_idle();
    check_memory("restart running");
    expect_copy(32'h0000_0c80, 32'h0000_0e00, 8'd5);
    start_unit(0);
    wait_idle();
    check_memory("restart after idle");
    report_test(5, "restart while busy", e);

    $display("5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/axi_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] awaddr,
  input  logic        wvalid,
  output logic        wready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wlast,
  output logic        bvalid,
  input  logic        bready,
  input  logic        arvalid,
  output logic        arready,
  input  logic [31:0] araddr,
  input  logic [7:0]  arlen,
  output logic        rvalid,
  input  logic        rready,
  output logic [31:0] rdata,
  output logic        rlast
);

  localparam int          WORDS = 1024;
  localparam logic [31:0] SEED  = 32'h7075_dc1a;

  logic [31:0] mem [WORDS];
  logic [31:0] stall_rnd;
  logic [9:0]  wa;
  logic [9:0]  ra;
  logic [7:0]  r_left;  // Read beats still to issue, minus one
  logic        w_busy;
  logic        r_busy;
  logic        go_w;
  logic        go_r;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper bits only, the low LCG bits repeat quickly
  assign go_w = (stall_rnd[31:30] != 2'b00);  // About one stall in four
  assign go_r = (stall_rnd[29:28] != 2'b00);

  initial begin : preload
    logic [31:0] x;
    x = SEED;
    for (int i = 0; i < WORDS; i++) begin
      x = lcg_next(x);
      mem[i] = x;
    end
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      stall_rnd <= SEED;
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rlast     <= 1'b0;
      rdata     <= '0;
      wa        <= '0;
      ra        <= '0;
      r_left    <= '0;
      w_busy    <= 1'b0;
      r_busy    <= 1'b0;
    end else begin
      stall_rnd <= lcg_next(stall_rnd);
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (!w_busy) begin
        awready <= awvalid && !awready && go_w;
        if (awvalid && awready) begin
          wa      <= awaddr[11:2];
          w_busy  <= 1'b1;
          awready <= 1'b0;
        end
      end else begin
        wready <= go_w;
        if (wvalid && wready) begin
          for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
              mem[wa][8*b +: 8] <= wdata[8*b +: 8];
            end
          end
          wa <= wa + 1'b1;
          if (wlast) begin
            w_busy <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b1;  // Single OKAY response
          end
        end
      end
      if (!r_busy) begin
        arready <= arvalid && !arready && go_r;
        if (arvalid && arready) begin
          ra      <= araddr[11:2];
          r_left  <= arlen;
          r_busy  <= 1'b1;
          arready <= 1'b0;
        end
      end else if (rvalid && rready && rlast) begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
        r_busy <= 1'b0;
      end else if (!rvalid || rready) begin
        rvalid <= go_r;  // A held beat never drops
        if (go_r) begin
          rdata  <= mem[ra];
          rlast  <= (r_left == 8'd0);
          ra     <= ra + 1'b1;
          r_left <= r_left - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 5;  // 10 ns clock
  localparam int RST_CYCLES  = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;  // Released on a rising edge
  end

endmodule

`default_nettype wire

// ==== verilog/copy_accel_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "copy_macros.svh"

module copy_accel_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         valid,
  input  logic [`COPY_REG_ADDR_W-1:0]  addr,
  input  copy_pkg::data_t              wdata,
  input  copy_pkg::strb_t              wstrb,
  output logic                         ready,
  output copy_pkg::data_t              rdata,
  output logic                         axi_awvalid,
  input  logic                         axi_awready,
  output copy_pkg::addr_t              axi_awaddr,
  output copy_pkg::len_t               axi_awlen,
  output logic [2:0]                   axi_awsize,
  output logic [1:0]                   axi_awburst,
  output logic                         axi_wvalid,
  input  logic                         axi_wready,
  output copy_pkg::data_t              axi_wdata,
  output copy_pkg::strb_t              axi_wstrb,
  output logic                         axi_wlast,
  output logic                         axi_bready,
  output logic                         axi_arvalid,
  input  logic                         axi_arready,
  output copy_pkg::addr_t              axi_araddr,
  output copy_pkg::len_t               axi_arlen,
  output logic [2:0]                   axi_arsize,
  output logic [1:0]                   axi_arburst,
  input  logic                         axi_rvalid,
  output logic                         axi_rready,
  input  copy_pkg::data_t              axi_rdata,
  input  logic                         axi_rlast
);
  import copy_pkg::*;

  logic [`COPY_N_UNITS-1:0]   busy;
  logic [`COPY_N_UNITS-1:0]   start;
  addr_t [`COPY_N_UNITS-1:0]  src;
  addr_t [`COPY_N_UNITS-1:0]  dst;
  len_t  [`COPY_N_UNITS-1:0]  len;

  // Unit master ports, one slice per engine
  logic [`COPY_N_UNITS-1:0]   s_valid;
  logic [`COPY_N_UNITS-1:0]   s_ready;
  logic [`COPY_N_UNITS-1:0]   s_last;
  addr_t [`COPY_N_UNITS-1:0]  s_addr;
  data_t [`COPY_N_UNITS-1:0]  s_wdata;
  strb_t [`COPY_N_UNITS-1:0]  s_wstrb;
  len_t  [`COPY_N_UNITS-1:0]  s_len;
  data_t                      s_rdata;

  logic   w_valid;
  logic   w_ready;
  addr_t  w_addr;
  data_t  w_data;
  strb_t  w_strb;
  len_t   w_len;
  logic   w_last;
  logic   r_valid;
  logic   r_ready;
  addr_t  r_addr;
  data_t  r_data;
  len_t   r_len;
  logic   r_last;

  copy_regs u_regs (.*);

  for (genvar u = 0; u < `COPY_N_UNITS; u++) begin : g_unit
    copy_engine u_engine (
      .clk       (clk),
      .rst       (rst),
      .start     (start[u]),
      .src       (src[u]),
      .dst       (dst[u]),
      .len       (len[u]),
      .req_ready (s_ready[u]),
      .req_last  (s_last[u]),
      .rdata     (s_rdata),
      .busy      (busy[u]),
      .req_valid (s_valid[u]),
      .req_addr  (s_addr[u]),
      .req_wdata (s_wdata[u]),
      .req_wstrb (s_wstrb[u]),
      .req_len   (s_len[u])
    );
  end

  burst_merge u_merge (.*);  // Names match the merged channels

  burst_to_axi u_bridge (.*);

endmodule

`default_nettype wire

// ==== verilog/burst_to_axi.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "copy_macros.svh"

module burst_to_axi (
  input  logic             clk,
  input  logic             rst,
  input  logic             w_valid,
  output logic             w_ready,
  input  copy_pkg::addr_t  w_addr,
  input  copy_pkg::data_t  w_data,
  input  copy_pkg::strb_t  w_strb,
  input  copy_pkg::len_t   w_len,
  output logic             w_last,
  input  logic             r_valid,
  output logic             r_ready,
  input  copy_pkg::addr_t  r_addr,
  output copy_pkg::data_t  r_data,
  input  copy_pkg::len_t   r_len,
  output logic             r_last,
  output logic             axi_awvalid,
  input  logic             axi_awready,
  output copy_pkg::addr_t  axi_awaddr,
  output copy_pkg::len_t   axi_awlen,
  output logic [2:0]       axi_awsize,
  output logic [1:0]       axi_awburst,
  output logic             axi_wvalid,
  input  logic             axi_wready,
  output copy_pkg::data_t  axi_wdata,
  output copy_pkg::strb_t  axi_wstrb,
  output logic             axi_wlast,
  output logic             axi_bready,
  output logic             axi_arvalid,
  input  logic             axi_arready,
  output copy_pkg::addr_t  axi_araddr,
  output copy_pkg::len_t   axi_arlen,
  output logic [2:0]       axi_arsize,
  output logic [1:0]       axi_arburst,
  input  logic             axi_rvalid,
  output logic             axi_rready,
  input  copy_pkg::data_t  axi_rdata,
  input  logic             axi_rlast
);
  import copy_pkg::*;

  localparam logic [2:0] BEAT_SIZE = 3'($clog2(`COPY_DATA_W / 8));

  bridge_state_t state;
  len_t          beat_cnt;  // Write beats sent in this burst

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= BR_IDLE;
      axi_awvalid <= 1'b0;
      axi_arvalid <= 1'b0;
      beat_cnt    <= '0;
    end else begin
      case (state)
        BR_IDLE: begin
          if (w_valid) begin  // Writes first
            axi_awvalid <= 1'b1;
            state       <= BR_AW;
          end else if (r_valid) begin
            axi_arvalid <= 1'b1;
            state       <= BR_AR;
          end
        end
        BR_AW: begin
          if (axi_awready) begin
            axi_awvalid <= 1'b0;
            state       <= BR_W;
          end
        end
        BR_W: begin
          if (axi_wvalid && axi_wready) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (axi_wlast) begin
              beat_cnt <= '0;
              state    <= BR_IDLE;
            end
          end
        end
        BR_AR: begin
          if (axi_arready) begin
            axi_arvalid <= 1'b0;
            state       <= BR_R;
          end
        end
        BR_R: begin
          if (axi_rvalid && axi_rready && axi_rlast) begin
            state <= BR_IDLE;
          end
        end
        default: state <= BR_IDLE;
      endcase
    end
  end

  assign axi_awaddr  = w_addr;
  assign axi_awlen   = w_len;
  assign axi_awsize  = BEAT_SIZE;
  assign axi_awburst = 2'b01;  // INCR
  assign axi_araddr  = r_addr;
  assign axi_arlen   = r_len;
  assign axi_arsize  = BEAT_SIZE;
  assign axi_arburst = 2'b01;

  assign axi_wvalid = (state == BR_W) && w_valid;
  assign axi_wdata  = w_data;
  assign axi_wstrb  = w_strb;
  assign axi_wlast  = (state == BR_W) && (beat_cnt == w_len);
  assign w_ready    = (state == BR_W) && axi_wready;
  assign w_last     = axi_wlast;
  assign axi_bready = 1'b1;  // Responses are dropped

  assign axi_rready = (state == BR_R) && r_valid;
  assign r_ready    = (state == BR_R) && axi_rvalid;
  assign r_data     = axi_rdata;
  assign r_last     = axi_rlast;

  a_aw_stable: assert property (@(posedge clk) disable iff (rst)
    axi_awvalid && !axi_awready |=>
      axi_awvalid && $stable(axi_awaddr) && $stable(axi_awlen));

endmodule

`default_nettype wire

// ==== verilog/burst_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "copy_macros.svh"

module burst_merge (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`COPY_N_UNITS-1:0]              s_valid,
  output logic [`COPY_N_UNITS-1:0]              s_ready,
  output logic [`COPY_N_UNITS-1:0]              s_last,
  input  copy_pkg::addr_t [`COPY_N_UNITS-1:0]   s_addr,
  input  copy_pkg::data_t [`COPY_N_UNITS-1:0]   s_wdata,
  input  copy_pkg::strb_t [`COPY_N_UNITS-1:0]   s_wstrb,
  input  copy_pkg::len_t  [`COPY_N_UNITS-1:0]   s_len,
  output copy_pkg::data_t                       s_rdata,
  output logic                                  w_valid,
  input  logic                                  w_ready,
  output copy_pkg::addr_t                       w_addr,
  output copy_pkg::data_t                       w_data,
  output copy_pkg::strb_t                       w_strb,
  output copy_pkg::len_t                        w_len,
  input  logic                                  w_last,
  output logic                                  r_valid,
  input  logic                                  r_ready,
  output copy_pkg::addr_t                       r_addr,
  input  copy_pkg::data_t                       r_data,
  output copy_pkg::len_t                        r_len,
  input  logic                                  r_last
);
  import copy_pkg::*;

  logic       w_running;
  unit_sel_t  w_unit;     // Owner of the write channel
  logic       r_running;
  unit_sel_t  r_unit;
  logic       w_req_any;
  unit_sel_t  w_req;
  logic       r_req_any;
  unit_sel_t  r_req;

  // Later index overrides, so the highest requester wins
  always_comb begin
    w_req_any = 1'b0;
    r_req_any = 1'b0;
    w_req     = '0;
    r_req     = '0;
    for (int i = 0; i < `COPY_N_UNITS; i++) begin
      if (s_valid[i] && (|s_wstrb[i])) begin
        w_req_any = 1'b1;
        w_req     = unit_sel_t'(i);
      end else if (s_valid[i]) begin
        r_req_any = 1'b1;
        r_req     = unit_sel_t'(i);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_running <= 1'b0;
      w_unit    <= '0;
      r_running <= 1'b0;
      r_unit    <= '0;
    end else begin
      if (!w_running && w_req_any) begin
        w_running <= 1'b1;
        w_unit    <= w_req;
      end else if (w_valid && w_ready && w_last) begin
        w_running <= 1'b0;
      end
      if (!r_running && r_req_any) begin
        r_running <= 1'b1;
        r_unit    <= r_req;
      end else if (r_valid && r_ready && r_last) begin
        r_running <= 1'b0;
      end
    end
  end

  assign w_valid = w_running && s_valid[w_unit];
  assign w_addr  = s_addr[w_unit];
  assign w_data  = s_wdata[w_unit];
  assign w_strb  = s_wstrb[w_unit];
  assign w_len   = s_len[w_unit];

  assign r_valid = r_running && s_valid[r_unit];
  assign r_addr  = s_addr[r_unit];
  assign r_len   = s_len[r_unit];
  assign s_rdata = r_data;  // Broadcast, only the owner sees ready

  always_comb begin
    s_ready = '0;
    s_last  = '0;
    if (w_running) begin
      s_ready[w_unit] = w_ready;
      s_last[w_unit]  = w_last;
    end
    if (r_running) begin
      s_ready[r_unit] = r_ready;
      s_last[r_unit]  = r_last;
    end
  end

  a_w_owner_holds: assert property (@(posedge clk) disable iff (rst)
    w_running |-> s_valid[w_unit]);
  a_r_owner_holds: assert property (@(posedge clk) disable iff (rst)
    r_running |-> s_valid[r_unit]);

endmodule

`default_nettype wire

// ==== verilog/copy_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "copy_macros.svh"

module copy_engine (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  copy_pkg::addr_t  src,
  input  copy_pkg::addr_t  dst,
  input  copy_pkg::len_t   len,
  input  logic             req_ready,
  input  logic             req_last,
  input  copy_pkg::data_t  rdata,
  output logic             busy,
  output logic             req_valid,
  output copy_pkg::addr_t  req_addr,
  output copy_pkg::data_t  req_wdata,
  output copy_pkg::strb_t  req_wstrb,
  output copy_pkg::len_t   req_len
);
  import copy_pkg::*;

  localparam int IDX_W = $clog2(`COPY_BUF_DEPTH);

  engine_state_t     state;
  addr_t             src_q;
  addr_t             dst_q;
  len_t              len_q;
  data_t             line_mem [`COPY_BUF_DEPTH];
  data_t             skid_q;
  logic              skid_vld;
  logic [IDX_W-1:0]  fill_idx;  // Next buffer word to fill
  logic [IDX_W-1:0]  out_idx;   // Next buffer word to send
  logic              rd_beat;
  logic              wr_beat;

  assign rd_beat = (state == ENG_RD_REQ) && req_ready;
  assign wr_beat = (state == ENG_WR_DATA) && req_ready;

  assign busy      = (state != ENG_IDLE);
  assign req_valid = (state == ENG_RD_REQ) || (state == ENG_WR_DATA);
  assign req_addr  = (state == ENG_WR_DATA) ? dst_q : src_q;
  assign req_wstrb = (state == ENG_WR_DATA) ? '1 : '0;  // Zero strobes select a read
  assign req_wdata = line_mem[out_idx];
  assign req_len   = len_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= ENG_IDLE;
      skid_vld <= 1'b0;
      fill_idx <= '0;
      out_idx  <= '0;
    end else begin
      skid_vld <= rd_beat;
      if (skid_vld) begin
        fill_idx <= fill_idx + 1'b1;
      end
      case (state)
        ENG_IDLE: begin
          if (start) begin
            state    <= ENG_RD_REQ;
            fill_idx <= '0;
            out_idx  <= '0;
          end
        end
        ENG_RD_REQ: begin
          if (rd_beat && req_last) begin
            state <= ENG_RD_DATA;
          end
        end
        ENG_RD_DATA: begin
          state <= ENG_WR_DATA;  // Last beat reaches the buffer here
        end
        ENG_WR_DATA: begin
          if (wr_beat) begin
            out_idx <= out_idx + 1'b1;
            if (req_last) begin
              state <= ENG_IDLE;
            end
          end
        end
      endcase
    end
  end

  // Configuration is sampled once per copy, so later register writes
  // cannot disturb a running burst
  always_ff @(posedge clk) begin
    if (start && (state == ENG_IDLE)) begin
      src_q <= src;
      dst_q <= dst;
      len_q <= (len > len_t'(`COPY_BUF_DEPTH - 1)) ? len_t'(`COPY_BUF_DEPTH - 1) : len;
    end
    if (rd_beat) begin
      skid_q <= rdata;  // Holds the beat off the AXI data path
    end
    if (skid_vld) begin
      line_mem[fill_idx] <= skid_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/copy_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "copy_macros.svh"

module copy_regs (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  valid,
  input  logic [`COPY_REG_ADDR_W-1:0]           addr,
  input  copy_pkg::data_t                       wdata,
  input  copy_pkg::strb_t                       wstrb,
  input  logic [`COPY_N_UNITS-1:0]              busy,
  output logic                                  ready,
  output copy_pkg::data_t                       rdata,
  output logic [`COPY_N_UNITS-1:0]              start,
  output copy_pkg::addr_t [`COPY_N_UNITS-1:0]   src,
  output copy_pkg::addr_t [`COPY_N_UNITS-1:0]   dst,
  output copy_pkg::len_t  [`COPY_N_UNITS-1:0]   len
);
  import copy_pkg::*;

  logic [`COPY_REG_ADDR_W-3:0] word;  // Word offset
  unit_sel_t                   unit;
  logic                        is_status;
  logic                        wr_en;

  assign word      = addr[`COPY_REG_ADDR_W-1:2];
  assign unit      = unit_sel_t'(word[3:2]);
  assign is_status = word[3];
  assign wr_en     = valid && ready && (|wstrb) && !is_status;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ready <= 1'b0;
    end else begin
      ready <= valid && !ready;  // One cycle per access
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (word[1:0])
        2'd0:    src[unit] <= wdata;
        2'd1:    dst[unit] <= wdata;
        2'd2:    len[unit] <= len_t'(wdata);
        default: ;  // CTRL only starts the unit
      endcase
    end
  end

  always_comb begin
    start = '0;
    if (wr_en && (word[1:0] == 2'd3) && !busy[unit]) begin
      start[unit] = 1'b1;  // Busy unit ignores the command
    end
  end

  always_comb begin
    if (is_status) begin
      rdata = data_t'(busy);
    end else begin
      case (word[1:0])
        2'd0:    rdata = src[unit];
        2'd1:    rdata = dst[unit];
        2'd2:    rdata = data_t'(len[unit]);
        default: rdata = data_t'(busy[unit]);
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/copy_pkg.sv ====
`default_nettype none

`include "copy_macros.svh"

package copy_pkg;

  typedef logic [`COPY_ADDR_W-1:0]           addr_t;
  typedef logic [`COPY_DATA_W-1:0]           data_t;
  typedef logic [`COPY_DATA_W/8-1:0]         strb_t;
  typedef logic [`COPY_LEN_W-1:0]            len_t;
  typedef logic [$clog2(`COPY_N_UNITS)-1:0]  unit_sel_t;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_RD_REQ,   // Read burst in flight
    ENG_RD_DATA,  // Skid drains into the buffer
    ENG_WR_DATA
  } engine_state_t;

  typedef enum logic [2:0] {BR_IDLE, BR_AW, BR_W, BR_AR, BR_R} bridge_state_t;

endpackage

`default_nettype wire

// ==== verilog/copy_macros.svh ====
`ifndef COPY_MACROS_SVH
`define COPY_MACROS_SVH

// Copy units sharing the memory port
`define COPY_N_UNITS     2

`define COPY_ADDR_W      32  // Byte address
`define COPY_DATA_W      32  // One AXI beat
`define COPY_LEN_W       8   // Beats minus one, as in AXI

// Local buffer per unit, limits LEN to 15
`define COPY_BUF_DEPTH   16

`define COPY_REG_ADDR_W  6   // Slave bus byte address

`endif
